// File: src/vdiv_cfg_pkg.sv
`default_nettype none

package vdiv_cfg_pkg;

  parameter int vlen_default      = 64;
  parameter int xlen              = 32;
  parameter int rob_width_default = 4;

  parameter int byte_width  = 8;
  parameter int hword_width = 16;
  parameter int word_width  = 32;

  // lower half of the vector bytes
  function automatic int lanes8(input int vlen);
    return vlen / byte_width / 2;
  endfunction

  // next quarter
  function automatic int lanes16(input int vlen);
    return vlen / hword_width / 2;
  endfunction

  // top quarter and all words at eew32
  function automatic int lanes32(input int vlen);
    return vlen / word_width;
  endfunction

  function automatic int lanes_total(input int vlen);
    return lanes8(vlen) + lanes16(vlen) + lanes32(vlen);
  endfunction

endpackage

`default_nettype wire

// File: src/vdiv_op_pkg.sv
`default_nettype none

package vdiv_op_pkg;

  // bit 0 marks the signed ops, bit 1 the remainder ops
  typedef enum logic [1:0] {
    op_divu = 2'b00,
    op_div  = 2'b01,
    op_remu = 2'b10,
    op_rem  = 2'b11
  } div_op_e;

  typedef enum logic {
    form_vv = 1'b0,
    form_vx = 1'b1
  } src_form_e;

  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  typedef enum logic [1:0] {
    st_idle = 2'b00,
    st_busy = 2'b01,
    st_done = 2'b10
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/vdiv_operand_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module vdiv_operand_unpack
  import vdiv_cfg_pkg::*;
  import vdiv_op_pkg::*;
#(
  parameter int VLEN = vlen_default
) (
  input  div_op_e                                   uop_op,
  input  src_form_e                                 uop_form,
  input  eew_e                                      uop_eew,
  input  logic [VLEN-1:0]                           vs2_data,
  input  logic [VLEN-1:0]                           vs1_data,
  input  logic [xlen-1:0]                           rs1_data,
  output logic                                      signed_op,
  output logic [lanes8(VLEN)-1:0][byte_width-1:0]   dividend8,
  output logic [lanes8(VLEN)-1:0][byte_width-1:0]   divisor8,
  output logic [lanes16(VLEN)-1:0][hword_width-1:0] dividend16,
  output logic [lanes16(VLEN)-1:0][hword_width-1:0] divisor16,
  output logic [lanes32(VLEN)-1:0][word_width-1:0]  dividend32,
  output logic [lanes32(VLEN)-1:0][word_width-1:0]  divisor32
);

  localparam int L8  = lanes8(VLEN);
  localparam int L16 = lanes16(VLEN);
  localparam int L32 = lanes32(VLEN);

  logic [VLEN-1:0] rs1_bcast;
  logic [VLEN-1:0] divisor_src;

  // element idx at width eew, extended to a full word
  function automatic logic [word_width-1:0] pick(input logic [VLEN-1:0] vec, input int idx,
                                                 input eew_e eew, input logic sgn);
    logic [byte_width-1:0]  b;
    logic [hword_width-1:0] h;
    logic [word_width-1:0]  w;
    b = '0;
    h = '0;
    case (eew)
      eew8: begin
        b = vec[idx*byte_width +: byte_width];
        w = {{(word_width-byte_width){sgn & b[byte_width-1]}}, b};
      end
      eew16: begin
        h = vec[idx*hword_width +: hword_width];
        w = {{(word_width-hword_width){sgn & h[hword_width-1]}}, h};
      end
      default: w = vec[idx*word_width +: word_width];
    endcase
    return w;
  endfunction

  assign signed_op = (uop_op == op_div) || (uop_op == op_rem);

  // scalar repeated at element width
  always_comb begin
    case (uop_eew)
      eew8:    rs1_bcast = {(VLEN / byte_width){rs1_data[byte_width-1:0]}};
      eew16:   rs1_bcast = {(VLEN / hword_width){rs1_data[hword_width-1:0]}};
      default: rs1_bcast = {(VLEN / word_width){rs1_data[word_width-1:0]}};
    endcase
  end

  assign divisor_src = (uop_form == form_vx) ? rs1_bcast : vs1_data;

  always_comb begin
    int idx16;
    int idx32;
    dividend8  = '0;
    divisor8   = '0;
    dividend16 = '0;
    divisor16  = '0;
    dividend32 = '0;
    divisor32  = '0;
    idx16      = 0;
    idx32      = 0;
    for (int j = 0; j < L8; j++) begin
      if (uop_eew == eew8) begin
        dividend8[j] = byte_width'(pick(vs2_data, j, uop_eew, signed_op));
        divisor8[j]  = byte_width'(pick(divisor_src, j, uop_eew, signed_op));
      end
    end
    // 16-bit lanes take bytes after the 8-bit lanes, or the low halfwords
    for (int j = 0; j < L16; j++) begin
      idx16 = (uop_eew == eew8) ? L8 + j : j;
      if (uop_eew != eew32) begin
        dividend16[j] = hword_width'(pick(vs2_data, idx16, uop_eew, signed_op));
        divisor16[j]  = hword_width'(pick(divisor_src, idx16, uop_eew, signed_op));
      end
    end
    for (int j = 0; j < L32; j++) begin
      case (uop_eew)
        eew8:    idx32 = L8 + L16 + j;
        eew16:   idx32 = L16 + j;
        default: idx32 = j;
      endcase
      dividend32[j] = pick(vs2_data, idx32, uop_eew, signed_op);
      divisor32[j]  = pick(divisor_src, idx32, uop_eew, signed_op);
    end
  end

endmodule

`default_nettype wire

// File: src/vdiv_lane_divider.sv
`timescale 1ns/1ps
`default_nettype none

module vdiv_lane_divider #(
  parameter int DIV_WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 signed_op,
  input  logic [DIV_WIDTH-1:0] dividend,
  input  logic [DIV_WIDTH-1:0] divisor,
  output logic [DIV_WIDTH-1:0] quotient,
  output logic [DIV_WIDTH-1:0] remainder,
  output logic                 done
);

  localparam int CNT_W = $clog2(DIV_WIDTH + 1);

  logic                 busy_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 done_q;
  logic [DIV_WIDTH-1:0] quo_q;
  logic [DIV_WIDTH-1:0] rem_q;
  logic [DIV_WIDTH-1:0] dvs_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;
  logic                 dvd_neg;
  logic                 dvs_neg;
  logic [DIV_WIDTH-1:0] dvd_mag;
  logic [DIV_WIDTH-1:0] dvs_mag;
  logic [DIV_WIDTH:0]   trial;

  assign dvd_neg = signed_op & dividend[DIV_WIDTH-1];
  assign dvs_neg = signed_op & divisor[DIV_WIDTH-1];
  assign dvd_mag = dvd_neg ? -dividend : dividend;
  assign dvs_mag = dvs_neg ? -divisor : divisor;

  // shift next dividend bit into the partial remainder, then subtract
  assign trial = {rem_q, quo_q[DIV_WIDTH-1]} - {1'b0, dvs_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(DIV_WIDTH);
      done_q <= 1'b0;
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo_q     <= dvd_mag;
      rem_q     <= '0;
      dvs_q     <= dvs_mag;
      // divide by zero keeps the all-ones quotient
      neg_quo_q <= (dvd_neg ^ dvs_neg) & (divisor != '0);
      neg_rem_q <= dvd_neg;
    end else if (busy_q) begin
      if (cnt_q != '0) begin
        if (!trial[DIV_WIDTH]) begin
          rem_q <= trial[DIV_WIDTH-1:0];
          quo_q <= {quo_q[DIV_WIDTH-2:0], 1'b1};
        end else begin
          rem_q <= {rem_q[DIV_WIDTH-2:0], quo_q[DIV_WIDTH-1]};
          quo_q <= {quo_q[DIV_WIDTH-2:0], 1'b0};
        end
      end else begin
        // sign fix
        if (neg_quo_q) begin
          quo_q <= -quo_q;
        end
        if (neg_rem_q) begin
          rem_q <= -rem_q;
        end
      end
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;
  assign done      = done_q;

endmodule

`default_nettype wire

// File: src/vdiv_result_pack.sv
`timescale 1ns/1ps
`default_nettype none

module vdiv_result_pack
  import vdiv_cfg_pkg::*;
  import vdiv_op_pkg::*;
#(
  parameter int VLEN = vlen_default
) (
  input  div_op_e                                   op_q,
  input  eew_e                                      eew_q,
  input  logic [lanes8(VLEN)-1:0][byte_width-1:0]   quotient8,
  input  logic [lanes8(VLEN)-1:0][byte_width-1:0]   remainder8,
  input  logic [lanes16(VLEN)-1:0][hword_width-1:0] quotient16,
  input  logic [lanes16(VLEN)-1:0][hword_width-1:0] remainder16,
  input  logic [lanes32(VLEN)-1:0][word_width-1:0]  quotient32,
  input  logic [lanes32(VLEN)-1:0][word_width-1:0]  remainder32,
  output logic [VLEN-1:0]                           result_data
);

  localparam int L8  = lanes8(VLEN);
  localparam int L16 = lanes16(VLEN);
  localparam int L32 = lanes32(VLEN);

  logic                             rem_sel;
  logic [L8-1:0][byte_width-1:0]    res8;
  logic [L16-1:0][hword_width-1:0]  res16;
  logic [L32-1:0][word_width-1:0]   res32;

  assign rem_sel = (op_q == op_remu) || (op_q == op_rem);
  assign res8    = rem_sel ? remainder8 : quotient8;
  assign res16   = rem_sel ? remainder16 : quotient16;
  assign res32   = rem_sel ? remainder32 : quotient32;

  // same element placement as the unpack side
  always_comb begin
    result_data = '0;
    case (eew_q)
      eew8: begin
        for (int j = 0; j < L8; j++) begin
          result_data[j*byte_width +: byte_width] = res8[j];
        end
        for (int j = 0; j < L16; j++) begin
          result_data[(L8+j)*byte_width +: byte_width] = byte_width'(res16[j]);
        end
        for (int j = 0; j < L32; j++) begin
          result_data[(L8+L16+j)*byte_width +: byte_width] = byte_width'(res32[j]);
        end
      end
      eew16: begin
        for (int j = 0; j < L16; j++) begin
          result_data[j*hword_width +: hword_width] = res16[j];
        end
        for (int j = 0; j < L32; j++) begin
          result_data[(L16+j)*hword_width +: hword_width] = hword_width'(res32[j]);
        end
      end
      default: begin
        for (int j = 0; j < L32; j++) begin
          result_data[j*word_width +: word_width] = res32[j];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/vdiv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vdiv_ctrl
  import vdiv_cfg_pkg::*;
  import vdiv_op_pkg::*;
#(
  parameter int VLEN      = vlen_default,
  parameter int ROB_WIDTH = rob_width_default
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         uop_valid,
  output logic                         uop_ready,
  input  div_op_e                      uop_op,
  input  eew_e                         uop_eew,
  input  logic [ROB_WIDTH-1:0]         uop_rob_entry,
  output logic                         lane_start,
  input  logic [lanes_total(VLEN)-1:0] lane_done,
  output div_op_e                      op_q,
  output eew_e                         eew_q,
  output logic                         result_valid,
  input  logic                         result_ready,
  output logic [ROB_WIDTH-1:0]         result_rob_entry
);

  ctrl_state_e          state_q;
  ctrl_state_e          state_d;
  logic                 accept;
  logic [ROB_WIDTH-1:0] rob_q;

  assign uop_ready    = (state_q == st_idle);
  assign accept       = uop_valid & uop_ready;
  assign lane_start   = accept;
  assign result_valid = (state_q == st_done);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (accept) state_d = st_busy;
      // lanes cleared their done on start, so this waits for this uop
      st_busy: if (&lane_done) state_d = st_done;
      st_done: if (result_ready) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // fields held for the whole flight of the uop
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= uop_op;
      eew_q <= uop_eew;
      rob_q <= uop_rob_entry;
    end
  end

  assign result_rob_entry = rob_q;

endmodule

`default_nettype wire

// File: src/vdiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vdiv_unit
  import vdiv_cfg_pkg::*;
  import vdiv_op_pkg::*;
#(
  parameter int VLEN      = vlen_default,
  parameter int ROB_WIDTH = rob_width_default
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 uop_valid,
  output logic                 uop_ready,
  input  div_op_e              uop_op,
  input  src_form_e            uop_form,
  input  eew_e                 uop_eew,
  input  logic [ROB_WIDTH-1:0] uop_rob_entry,
  input  logic [VLEN-1:0]      vs2_data,
  input  logic [VLEN-1:0]      vs1_data,
  input  logic [xlen-1:0]      rs1_data,
  output logic                 result_valid,
  input  logic                 result_ready,
  output logic [ROB_WIDTH-1:0] result_rob_entry,
  output logic [VLEN-1:0]      result_data
);

  localparam int L8  = lanes8(VLEN);
  localparam int L16 = lanes16(VLEN);
  localparam int L32 = lanes32(VLEN);

  logic                            lane_start;
  logic                            signed_op;
  div_op_e                         op_q;
  eew_e                            eew_q;
  logic [L8-1:0]                   done8;
  logic [L16-1:0]                  done16;
  logic [L32-1:0]                  done32;
  logic [L8-1:0][byte_width-1:0]   dividend8;
  logic [L8-1:0][byte_width-1:0]   divisor8;
  logic [L8-1:0][byte_width-1:0]   quotient8;
  logic [L8-1:0][byte_width-1:0]   remainder8;
  logic [L16-1:0][hword_width-1:0] dividend16;
  logic [L16-1:0][hword_width-1:0] divisor16;
  logic [L16-1:0][hword_width-1:0] quotient16;
  logic [L16-1:0][hword_width-1:0] remainder16;
  logic [L32-1:0][word_width-1:0]  dividend32;
  logic [L32-1:0][word_width-1:0]  divisor32;
  logic [L32-1:0][word_width-1:0]  quotient32;
  logic [L32-1:0][word_width-1:0]  remainder32;

  vdiv_ctrl #(
    .VLEN             (VLEN),
    .ROB_WIDTH        (ROB_WIDTH)
  ) u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .uop_valid        (uop_valid),
    .uop_ready        (uop_ready),
    .uop_op           (uop_op),
    .uop_eew          (uop_eew),
    .uop_rob_entry    (uop_rob_entry),
    .lane_start       (lane_start),
    .lane_done        ({done32, done16, done8}),
    .op_q             (op_q),
    .eew_q            (eew_q),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result_rob_entry (result_rob_entry)
  );

  vdiv_operand_unpack #(
    .VLEN       (VLEN)
  ) u_unpack (
    .uop_op     (uop_op),
    .uop_form   (uop_form),
    .uop_eew    (uop_eew),
    .vs2_data   (vs2_data),
    .vs1_data   (vs1_data),
    .rs1_data   (rs1_data),
    .signed_op  (signed_op),
    .dividend8  (dividend8),
    .divisor8   (divisor8),
    .dividend16 (dividend16),
    .divisor16  (divisor16),
    .dividend32 (dividend32),
    .divisor32  (divisor32)
  );

  for (genvar j = 0; j < L8; j++) begin : g_div8
    vdiv_lane_divider #(
      .DIV_WIDTH (byte_width)
    ) u_div (
      .clk       (clk),
      .rst       (rst),
      .start     (lane_start),
      .signed_op (signed_op),
      .dividend  (dividend8[j]),
      .divisor   (divisor8[j]),
      .quotient  (quotient8[j]),
      .remainder (remainder8[j]),
      .done      (done8[j])
    );
  end

  for (genvar j = 0; j < L16; j++) begin : g_div16
    vdiv_lane_divider #(
      .DIV_WIDTH (hword_width)
    ) u_div (
      .clk       (clk),
      .rst       (rst),
      .start     (lane_start),
      .signed_op (signed_op),
      .dividend  (dividend16[j]),
      .divisor   (divisor16[j]),
      .quotient  (quotient16[j]),
      .remainder (remainder16[j]),
      .done      (done16[j])
    );
  end

  // widest lanes set the latency
  for (genvar j = 0; j < L32; j++) begin : g_div32
    vdiv_lane_divider #(
      .DIV_WIDTH (word_width)
    ) u_div (
      .clk       (clk),
      .rst       (rst),
      .start     (lane_start),
      .signed_op (signed_op),
      .dividend  (dividend32[j]),
      .divisor   (divisor32[j]),
      .quotient  (quotient32[j]),
      .remainder (remainder32[j]),
      .done      (done32[j])
    );
  end

  vdiv_result_pack #(
    .VLEN        (VLEN)
  ) u_pack (
    .op_q        (op_q),
    .eew_q       (eew_q),
    .quotient8   (quotient8),
    .remainder8  (remainder8),
    .quotient16  (quotient16),
    .remainder16 (remainder16),
    .quotient32  (quotient32),
    .remainder32 (remainder32),
    .result_data (result_data)
  );

endmodule

`default_nettype wire

// File: test/vdiv_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module vdiv_unit_assertions
  import vdiv_cfg_pkg::*;
#(
  parameter int VLEN      = vlen_default,
  parameter int ROB_WIDTH = rob_width_default
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 uop_ready,
  input logic                 result_valid,
  input logic                 result_ready,
  input logic [ROB_WIDTH-1:0] result_rob_entry,
  input logic [VLEN-1:0]      result_data
);

  // cycles in flight since acceptance
  logic [7:0] busy_cycles;

  always_ff @(posedge clk) begin
    if (rst || result_valid || uop_ready) begin
      busy_cycles <= '0;
    end else begin
      busy_cycles <= busy_cycles + 8'd1;
    end
  end

  a_reset_idle: assert property (@(posedge clk) rst |=> !result_valid && uop_ready)
    else $error("unit not idle after reset");

  a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
                                    !uop_ready && !(result_valid && result_ready) |=>
                                    !uop_ready)
    else $error("uop_ready rose before the result transfer");

  a_hold_result: assert property (@(posedge clk) disable iff (rst)
                                  result_valid && !result_ready |=>
                                  result_valid && $stable(result_data) &&
                                  $stable(result_rob_entry))
    else $error("result changed under back-pressure");

  a_latency: assert property (@(posedge clk) disable iff (rst) busy_cycles <= 8'd64)
    else $error("no result within 64 cycles of acceptance");

endmodule

bind vdiv_unit vdiv_unit_assertions #(
  .VLEN             (VLEN),
  .ROB_WIDTH        (ROB_WIDTH)
) u_assertions (
  .clk              (clk),
  .rst              (rst),
  .uop_ready        (uop_ready),
  .result_valid     (result_valid),
  .result_ready     (result_ready),
  .result_rob_entry (result_rob_entry),
  .result_data      (result_data)
);

`default_nettype wire

// File: test/tb_vdiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vdiv_unit
  import vdiv_cfg_pkg::*;
  import vdiv_op_pkg::*;
();

  localparam int VLEN      = vlen_default;
  localparam int ROB_WIDTH = rob_width_default;
  localparam int MAX_TESTS = 32;
  localparam int WORDS     = 8;
  localparam int LAT_BOUND = 64;
  localparam int SLACK     = 16;

  logic                 clk;
  logic                 rst;
  logic                 uop_valid;
  logic                 uop_ready;
  div_op_e              uop_op;
  src_form_e            uop_form;
  eew_e                 uop_eew;
  logic [ROB_WIDTH-1:0] uop_rob_entry;
  logic [VLEN-1:0]      vs2_data;
  logic [VLEN-1:0]      vs1_data;
  logic [xlen-1:0]      rs1_data;
  logic                 result_valid;
  logic                 result_ready;
  logic [ROB_WIDTH-1:0] result_rob_entry;
  logic [VLEN-1:0]      result_data;

  // word 0 is the test count, then WORDS words per test
  logic [VLEN-1:0] test_mem [0:MAX_TESTS*WORDS];
  int              num_tests;
  int              cycle_count = 0;
  int              cycle_limit = 0;
  integer          seed;

  vdiv_unit #(
    .VLEN             (VLEN),
    .ROB_WIDTH        (ROB_WIDTH)
  ) u_dut (
    .clk              (clk),
    .rst              (rst),
    .uop_valid        (uop_valid),
    .uop_ready        (uop_ready),
    .uop_op           (uop_op),
    .uop_form         (uop_form),
    .uop_eew          (uop_eew),
    .uop_rob_entry    (uop_rob_entry),
    .vs2_data         (vs2_data),
    .vs1_data         (vs1_data),
    .rs1_data         (rs1_data),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  // limit is zero until the test file is read
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      abort_run($sformatf("run timed out after %0d cycles", cycle_count));
    end
  end

  task automatic check_data(input logic [VLEN-1:0] exp_data,
                            input logic [ROB_WIDTH-1:0] exp_tag);
    if (result_rob_entry !== exp_tag) begin
      $display("ERR %0t result_rob_entry expected %h got %h", $time, exp_tag,
               result_rob_entry);
      abort_run("result tag mismatch");
    end
    if (result_data !== exp_data) begin
      $display("ERR %0t result_data expected %h got %h", $time, exp_data, result_data);
      abort_run("result data mismatch");
    end
  endtask

  task automatic check_eew_op(input div_op_e exp_op, input eew_e exp_eew);
    div_op_e got_op;
    eew_e    got_eew;
    got_op  = u_dut.op_q;
    got_eew = u_dut.eew_q;
    if (got_op !== exp_op) begin
      $display("ERR %0t op_q expected %s got %s", $time, exp_op.name(), got_op.name());
      abort_run("latched opcode mismatch");
    end
    if (got_eew !== exp_eew) begin
      $display("ERR %0t eew_q expected %s got %s (op %s)", $time, exp_eew.name(),
               got_eew.name(), exp_op.name());
      abort_run("latched element width mismatch");
    end
  endtask

  // called 2 ns after a rising edge
  task automatic issue_uop(input int base);
    bit accepted;
    accepted      = 1'b0;
    uop_op        = div_op_e'(test_mem[base][1:0]);
    uop_form      = src_form_e'(test_mem[base+1][0]);
    uop_eew       = eew_e'(test_mem[base+2][1:0]);
    uop_rob_entry = test_mem[base+3][ROB_WIDTH-1:0];
    vs2_data      = test_mem[base+4];
    vs1_data      = test_mem[base+5];
    rs1_data      = test_mem[base+6][xlen-1:0];
    uop_valid     = 1'b1;
    while (!accepted) begin
      accepted = uop_ready;
      @(posedge clk);
      #2;
    end
    uop_valid = 1'b0;
  endtask

  // data must match on every cycle it is offered under random back-pressure
  task automatic collect_result(input logic [VLEN-1:0] exp_data,
                                input logic [ROB_WIDTH-1:0] exp_tag,
                                input div_op_e exp_op, input eew_e exp_eew);
    logic [31:0] rnd;
    bit          taken;
    taken = 1'b0;
    while (!taken) begin
      rnd          = $random(seed);
      result_ready = rnd[0];
      if (result_valid) begin
        check_data(exp_data, exp_tag);
        check_eew_op(exp_op, exp_eew);
        if (uop_ready) begin
          $display("ERR %0t uop_ready expected 0 got 1", $time);
          abort_run("uop_ready high while a result is pending");
        end
        taken = result_ready;
      end
      @(posedge clk);
      #2;
    end
    result_ready = 1'b0;
  endtask

  initial begin
    int base;
    rst           = 1'b1;
    uop_valid     = 1'b0;
    uop_op        = op_divu;
    uop_form      = form_vv;
    uop_eew       = eew8;
    uop_rob_entry = '0;
    vs2_data      = '0;
    vs1_data      = '0;
    rs1_data      = '0;
    result_ready  = 1'b0;
    seed          = 32'hf43b_4dea;
    $readmemh("test/vdiv_tests.txt", test_mem);
    num_tests = int'(test_mem[0]);
    if (num_tests < 1 || num_tests > MAX_TESTS) begin
      abort_run("test file holds no usable test count");
    end
    cycle_limit = num_tests * (LAT_BOUND + SLACK);
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      base = 1 + t * WORDS;
      issue_uop(base);
      collect_result(test_mem[base+7], test_mem[base+3][ROB_WIDTH-1:0],
                     div_op_e'(test_mem[base][1:0]), eew_e'(test_mem[base+2][1:0]));
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/vdiv_tests.txt
// first value: number of tests in hex
// per test: op form eew tag vs2 vs1 rs1 expected (op 0 divu 1 div 2 remu 3 rem, eew 0/1/2)
14
0 0 0 1 c864ff0a502107fe 0a07110b10050203 00000000 140e0f0005060354
2 0 0 2 c864ff0a502107fe 0a07110b10050203 00000000 0002000a00030102
0 0 1 3 03e880001234ffff 0007000300100100 00000000 008e2aaa012300ff
2 0 1 4 03e880001234ffff 0007000300100100 00000000 00060002000400ff
0 0 2 5 12345678ffffffff 0000010000010000 00000000 001234560000ffff
2 0 2 6 12345678ffffffff 0000010000010000 00000000 000000780000ffff
1 0 0 7 ff7f809c64f907f9 05f60309f9fefe02 00000000 00f4d6f5f203fdfd
3 0 0 8 ff7f809c64f907f9 05f60309f9fefe02 00000000 ff07feff02ff01ff
1 0 1 9 fffb80007530fc18 fffd0100fed40007 00000000 0001ff80ff9cff72
3 0 1 a fffb80007530fc18 fffd0100fed40007 00000000 fffe00000000fffa
1 0 2 b 7ffffffffffe7960 fffffffe00000007 00000000 c0000001ffffc833
3 0 2 c 7ffffffffffe7960 fffffffe00000007 00000000 00000001fffffffb
0 1 0 d c804806300ff140a 0102030405060708 12345605 2800191300330402
3 1 1 e 80000007ff9c0064 0102030405060708 abcdfff9 ffff0000fffe0002
1 1 2 f fffffff70000000a 0102030405060708 fffffffd 00000003fffffffd
0 0 0 0 0123456789abcdef 0000000000000000 00000000 ffffffffffffffff
3 0 1 1 80007ffffff01234 0000000000000000 00000000 80007ffffff01234
1 0 0 2 8080808080808080 ffffffffffffffff 00000000 8080808080808080
3 0 2 3 8000000080000000 ffffffffffffffff 00000000 0000000000000000
1 1 1 4 8000fff000057fff 0102030405060708 ffff0000 ffffffffffffffff

// File: verilog.f
src/vdiv_cfg_pkg.sv
src/vdiv_op_pkg.sv
src/vdiv_operand_unpack.sv
src/vdiv_lane_divider.sv
src/vdiv_result_pack.sv
src/vdiv_ctrl.sv
src/vdiv_unit.sv
test/vdiv_unit_assertions.sv
test/tb_vdiv_unit.sv

// File: Makefile
TOP := tb_vdiv_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
